/* design/acq_pkg.sv */
// ---------------------------------------------------------------------------
// Shared timing constants and state encodings for the acquisition front end.
// BIT_TICKS fixes the serial bit period in clock cycles and is not
// programmable. Channel count and index width must stay consistent.
// ---------------------------------------------------------------------------
`default_nettype none

package acq_pkg;

	// clock cycles per serial bit
	localparam int BIT_TICKS = 105;
	// width of the bit period counter
	localparam int TICK_W = $clog2(BIT_TICKS);
	// multiplexer channel index
	localparam int CHAN_W = 3;
	localparam int NUM_CHAN = 8;

	// conversion sequencer
	typedef enum logic [2:0] {
		seq_idle,
		seq_settle,
		seq_start,
		seq_wait_eoc,
		seq_capture,
		seq_request,
		seq_wait_ready
	} seq_state_t;

	// transmit scheduler
	typedef enum logic [1:0] {
		sched_idle,
		sched_shot,
		sched_wait_confirm,
		sched_gap
	} sched_state_t;

	// line interface
	typedef enum logic [1:0] {
		itfc_idle,
		itfc_load,
		itfc_send,
		itfc_wait_end
	} itfc_state_t;

	// serializer bit position, the bit currently on the line
	typedef enum logic [3:0] {
		start_bit,
		bit0,
		bit1,
		bit2,
		bit3,
		bit4,
		bit5,
		bit6,
		bit7,
		stop_bit
	} frame_state_t;

endpackage

`default_nettype wire

/* design/conv_sequencer.sv */
// ---------------------------------------------------------------------------
// Conversion sequencer. Steps the analog multiplexer through NUM_CHAN
// channels, starts the converter and waits for an active high eoc.
// The eoc wait has no timeout. A new conversion starts only after the
// scheduler has acknowledged the previous result with send_done.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer
	import acq_pkg::*;
(
	input  logic              clock,
	input  logic              rst,
	input  logic              eoc,
	input  logic              send_done,
	output logic              mux_en,
	output logic              soc,
	output logic              load_dato,
	output logic              send_req,
	output logic [CHAN_W-1:0] canale
);

	seq_state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= seq_idle;
			mux_en    <= 1'b0;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			send_req  <= 1'b0;
			canale    <= '0;
		end else begin
			// load_dato is a single cycle strobe
			load_dato <= 1'b0;
			case (state)
				seq_idle: begin
					// enable the mux for the current channel
					mux_en <= 1'b1;
					state  <= seq_settle;
				end
				seq_settle: begin
					// one cycle for the mux output to settle
					state <= seq_start;
				end
				seq_start: begin
					// soc goes up two cycles after mux_en
					soc   <= 1'b1;
					state <= seq_wait_eoc;
				end
				seq_wait_eoc: begin
					// wait as long as the converter needs
					if (eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= seq_capture;
					end
				end
				seq_capture: begin
					// data_in is valid now, drop soc and advance the channel
					soc <= 1'b0;
					if (canale == CHAN_W'(NUM_CHAN - 1)) begin
						canale <= '0;
					end else begin
						canale <= canale + 1'b1;
					end
					state <= seq_request;
				end
				seq_request: begin
					send_req <= 1'b1;
					state    <= seq_wait_ready;
				end
				seq_wait_ready: begin
					// both frames of the pair are out
					if (send_done) begin
						send_req <= 1'b0;
						state    <= seq_idle;
					end
				end
				default: begin
					state <= seq_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/tx_scheduler.sv */
// ---------------------------------------------------------------------------
// Transmit scheduler. Turns one send_req into two shots, the first with
// add_mpx2 low and the second with add_mpx2 high. A dropped frame is
// confirmed like a sent one, so the pair always completes.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tx_scheduler
	import acq_pkg::*;
(
	input  logic clock,
	input  logic rst,
	input  logic send_req,
	input  logic confirm,
	output logic send_done,
	output logic shot,
	output logic add_mpx2
);

	sched_state_t state;
	// set while the second half of the pair is in flight
	logic half;

	// the half flag selects the second mux bank directly
	assign add_mpx2 = half;

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= sched_idle;
			half      <= 1'b0;
			shot      <= 1'b0;
			send_done <= 1'b0;
		end else begin
			// shot and send_done are one cycle strobes
			shot      <= 1'b0;
			send_done <= 1'b0;
			case (state)
				sched_idle: begin
					if (send_req) begin
						state <= sched_shot;
					end
				end
				sched_shot: begin
					// first frame of the pair
					shot  <= 1'b1;
					state <= sched_wait_confirm;
				end
				sched_wait_confirm: begin
					if (confirm) begin
						if (!half) begin
							// second shot right after the first confirm
							half <= 1'b1;
							shot <= 1'b1;
						end else begin
							half      <= 1'b0;
							send_done <= 1'b1;
							state     <= sched_gap;
						end
					end
				end
				sched_gap: begin
					// lets the sequencer drop send_req before we look again
					state <= sched_idle;
				end
				default: begin
					state <= sched_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/line_interface.sv */
// ---------------------------------------------------------------------------
// Line interface. Captures data_in after a shot and starts the serializer
// if dsr is high. With dsr low the frame is dropped, error rises and the
// shot is confirmed anyway. error holds until a frame starts again.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_interface
	import acq_pkg::*;
(
	input  logic       clock,
	input  logic       rst,
	input  logic       shot,
	input  logic       dsr,
	input  logic       tx_end,
	input  logic [7:0] data_in,
	output logic       confirm,
	output logic       error,
	output logic       tx_start,
	output logic [7:0] tx_byte
);

	itfc_state_t state;

	// transmit buffer, loaded once per shot
	always_ff @(posedge clock) begin
		if (state == itfc_load) begin
			tx_byte <= data_in;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= itfc_idle;
			confirm  <= 1'b0;
			error    <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			confirm  <= 1'b0;
			tx_start <= 1'b0;
			case (state)
				itfc_idle: begin
					if (shot) begin
						state <= itfc_load;
					end
				end
				itfc_load: begin
					// buffer takes data_in on this edge
					state <= itfc_send;
				end
				itfc_send: begin
					if (dsr) begin
						// tx_byte is already stable for the serializer
						tx_start <= 1'b1;
						error    <= 1'b0;
						state    <= itfc_wait_end;
					end else begin
						// no receiver, drop the frame but keep the pair going
						error   <= 1'b1;
						confirm <= 1'b1;
						state   <= itfc_idle;
					end
				end
				itfc_wait_end: begin
					if (tx_end) begin
						confirm <= 1'b1;
						state   <= itfc_idle;
					end
				end
				default: begin
					state <= itfc_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_serializer.sv */
// ---------------------------------------------------------------------------
// Bit serializer. One start bit, eight data bits MSB first, one stop bit,
// no parity. Every bit is BIT_TICKS cycles. The start bit follows tx_start
// after a lead-in of BIT_TICKS idle cycles. tx_start must not come while
// a frame is still going out.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_serializer
	import acq_pkg::*;
(
	input  logic       clock,
	input  logic       rst,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       data_out,
	output logic       tx_end
);

	frame_state_t      ptr;
	logic              busy;
	// high during the idle lead-in before the start bit
	logic              lead;
	logic [TICK_W-1:0] tick;
	logic [7:0]        shreg;
	logic              bit_done;
	logic              shift;

	// last cycle of the current bit period
	assign bit_done = busy && (tick == TICK_W'(BIT_TICKS - 1));
	// a data bit leaves the shift register at the start bit and bit0..bit6 ends
	assign shift = bit_done && !lead && (ptr != bit7) && (ptr != stop_bit);
	assign tx_end = bit_done && !lead && (ptr == stop_bit);

	always_ff @(posedge clock) begin
		if (tx_start) begin
			shreg <= tx_byte;
		end else if (shift) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			busy     <= 1'b0;
			lead     <= 1'b0;
			tick     <= '0;
			ptr      <= start_bit;
			data_out <= 1'b1;
		end else if (tx_start) begin
			busy <= 1'b1;
			lead <= 1'b1;
			tick <= '0;
		end else if (busy) begin
			if (bit_done) begin
				tick <= '0;
				if (lead) begin
					lead     <= 1'b0;
					ptr      <= start_bit;
					data_out <= 1'b0;
				end else begin
					// MSB goes first
					if (shift) begin
						data_out <= shreg[7];
					end
					case (ptr)
						start_bit: ptr <= bit0;
						bit0:      ptr <= bit1;
						bit1:      ptr <= bit2;
						bit2:      ptr <= bit3;
						bit3:      ptr <= bit4;
						bit4:      ptr <= bit5;
						bit5:      ptr <= bit6;
						bit6:      ptr <= bit7;
						bit7: begin
							ptr      <= stop_bit;
							data_out <= 1'b1;
						end
						default: begin
							// end of stop bit, line stays high
							busy <= 1'b0;
							ptr  <= start_bit;
						end
					endcase
				end
			end else begin
				tick <= tick + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/acq_top.sv */
// ---------------------------------------------------------------------------
// Acquisition front end top level. Single clock, synchronous active high
// reset. eoc is active high. Transmit only, fixed bit period, no parity.
// Each conversion yields two frames, add_mpx2 low then high.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module acq_top
	import acq_pkg::*;
(
	input  logic              clock,
	input  logic              rst,
	input  logic              eoc,
	input  logic              dsr,
	input  logic [7:0]        data_in,
	output logic              soc,
	output logic              load_dato,
	output logic              mux_en,
	output logic              add_mpx2,
	output logic              error,
	output logic              data_out,
	output logic [CHAN_W-1:0] canale
);

	// sequencer to scheduler
	logic       send_req;
	logic       send_done;
	// scheduler to line interface
	logic       shot;
	logic       confirm;
	// line interface to serializer
	logic       tx_start;
	logic       tx_end;
	logic [7:0] tx_byte;

	conv_sequencer i_conv_sequencer (
		.clock     (clock),
		.rst       (rst),
		.eoc       (eoc),
		.send_done (send_done),
		.mux_en    (mux_en),
		.soc       (soc),
		.load_dato (load_dato),
		.send_req  (send_req),
		.canale    (canale)
	);

	tx_scheduler i_tx_scheduler (
		.clock     (clock),
		.rst       (rst),
		.send_req  (send_req),
		.confirm   (confirm),
		.send_done (send_done),
		.shot      (shot),
		.add_mpx2  (add_mpx2)
	);

	line_interface i_line_interface (
		.clock    (clock),
		.rst      (rst),
		.shot     (shot),
		.dsr      (dsr),
		.tx_end   (tx_end),
		.data_in  (data_in),
		.confirm  (confirm),
		.error    (error),
		.tx_start (tx_start),
		.tx_byte  (tx_byte)
	);

	uart_serializer i_uart_serializer (
		.clock    (clock),
		.rst      (rst),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.data_out (data_out),
		.tx_end   (tx_end)
	);

endmodule

`default_nettype wire

/* verif/acq_tb.sv */
// ---------------------------------------------------------------------------
// Testbench for the acquisition front end. Models the converter with a
// random eoc delay, decodes both serial frames of every conversion and
// holds dsr low for one conversion. DUT outputs are sampled on the falling
// clock edge. The run stops at the first failed check or on timeout.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module acq_tb
	import acq_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	// conversions observed before the run ends
	localparam int NUM_CONV = 12;
	// conversion (counted from 1) that runs with dsr low
	localparam int DROP_CONV = 5;
	localparam logic [31:0] SEED = 32'd28315;
	// 12 bit periods per frame leave room for the lead-in and handshakes
	localparam int TIMEOUT_NS = NUM_CONV * 2 * 12 * BIT_TICKS * CLK_PERIOD + 50000;

	logic              clock;
	logic              rst;
	logic              eoc;
	logic              dsr;
	logic [7:0]        data_in;
	logic              soc;
	logic              load_dato;
	logic              mux_en;
	logic              add_mpx2;
	logic              error;
	logic              data_out;
	logic [CHAN_W-1:0] canale;

	// byte that both frames of the current conversion must carry
	logic [7:0] exp_byte;
	// load_dato pulses seen so far
	int         mon_conv;
	// frames decoded for the current conversion
	int         frames_in_conv;

	acq_top i_acq_top (
		.clock     (clock),
		.rst       (rst),
		.eoc       (eoc),
		.dsr       (dsr),
		.data_in   (data_in),
		.soc       (soc),
		.load_dato (load_dato),
		.mux_en    (mux_en),
		.add_mpx2  (add_mpx2),
		.error     (error),
		.data_out  (data_out),
		.canale    (canale)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "check failed");
	endtask

	// outputs and every state machine at their reset values
	task automatic check_reset_state();
		assert (!soc && !load_dato && !mux_en && !add_mpx2 && !error)
			else report_failure("control output not low in reset");
		assert (data_out === 1'b1) else report_failure("data_out not high in reset");
		assert (canale == '0) else report_failure("channel not 0 in reset");
		assert (i_acq_top.i_conv_sequencer.state == seq_idle)
			else report_failure("sequencer not idle in reset");
		assert (i_acq_top.i_tx_scheduler.state == sched_idle)
			else report_failure("scheduler not idle in reset");
		assert (i_acq_top.i_line_interface.state == itfc_idle)
			else report_failure("line interface not idle in reset");
		assert (i_acq_top.i_uart_serializer.ptr == start_bit)
			else report_failure("serializer not at start bit in reset");
	endtask

	initial begin : clock_gen
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout, the conversions did not finish within %0d ns", TIMEOUT_NS);
		$display("Some tests failed");
		$fatal(1, "timeout");
	end

	// converter model that also supplies data_in and dsr per conversion
	initial begin : converter_model
		logic [31:0] rng;
		int          delay;
		int          conv;
		rng = SEED;
		conv = 0;
		forever begin
			do @(posedge clock); while (rst || !soc);
			rng = xorshift32(rng);
			delay = 1 + int'(rng % 32'd20);
			repeat (delay - 1) @(posedge clock);
			eoc <= 1'b1;
			// new result byte with load_dato
			// eoc drops once soc is gone
			do begin
				@(posedge clock);
				if (load_dato) begin
					conv++;
					rng = xorshift32(rng);
					data_in <= rng[7:0];
					exp_byte = rng[7:0];
					dsr <= (conv != DROP_CONV);
				end
			end while (soc);
			eoc <= 1'b0;
		end
	end

	// sequencing, channel order and pair completion
	initial begin : protocol_monitor
		logic load_prev;
		logic eoc_prev;
		logic mux_prev;
		logic soc_prev;
		logic pending;
		int   cycle;
		int   mux_rise_cycle;
		do @(negedge clock); while (rst);
		load_prev = 1'b0;
		eoc_prev = eoc;
		mux_prev = mux_en;
		soc_prev = soc;
		pending = 1'b0;
		cycle = 0;
		mux_rise_cycle = 0;
		forever begin
			@(negedge clock);
			cycle++;
			if (load_dato) begin
				assert (soc) else report_failure("load_dato while soc low");
				assert (eoc_prev) else report_failure("load_dato without eoc");
				assert (!mux_en) else report_failure("mux_en high at load_dato");
				mon_conv++;
				frames_in_conv = 0;
				pending = 1'b1;
				// dropped frames leave error set until a frame starts
				if (mon_conv == DROP_CONV + 1) begin
					assert (error) else report_failure("error cleared without a frame");
				end
			end
			if (load_prev) begin
				assert (canale == CHAN_W'(mon_conv % NUM_CHAN)) else report_failure(
					$sformatf("channel %0d after conversion %0d", canale, mon_conv));
			end
			if (mux_en && !mux_prev) begin
				mux_rise_cycle = cycle;
				if (mon_conv > 0) begin
					// the next conversion may only start once the pair is done
					assert (pending) else report_failure("mux_en rose twice");
					assert (frames_in_conv == ((mon_conv == DROP_CONV) ? 0 : 2))
						else report_failure($sformatf("%0d frames for conversion %0d",
							frames_in_conv, mon_conv));
					assert (error == (mon_conv == DROP_CONV))
						else report_failure($sformatf("error %0b after conversion %0d",
							error, mon_conv));
					pending = 1'b0;
				end
			end
			if (soc && !soc_prev) begin
				assert (mux_en && (cycle - mux_rise_cycle == 2))
					else report_failure("soc not two cycles after mux_en");
			end
			load_prev = load_dato;
			eoc_prev = eoc;
			mux_prev = mux_en;
			soc_prev = soc;
		end
	end

	// samples each bit at mid-period and checks it is stable for BIT_TICKS
	initial begin : frame_decoder
		logic [9:0] bits;
		logic [7:0] got;
		logic       level;
		logic       half;
		forever begin
			@(negedge clock);
			if (!rst && data_out === 1'b0) begin
				// first cycle of the start bit
				assert (frames_in_conv < 2) else report_failure("third frame in one pair");
				assert (mon_conv != DROP_CONV) else report_failure("frame sent with dsr low");
				assert (!error) else report_failure("error high while a frame is sent");
				half = (frames_in_conv == 1);
				for (int b = 0; b < 10; b++) begin
					for (int t = 0; t < BIT_TICKS; t++) begin
						if (b != 0 || t != 0) begin
							@(negedge clock);
						end
						if (t == 0) begin
							level = data_out;
						end
						if (t == BIT_TICKS / 2) begin
							bits[b] = data_out;
						end
						assert (data_out === level) else report_failure(
							$sformatf("bit %0d changed inside its period", b));
						assert (add_mpx2 == half) else report_failure(
							$sformatf("add_mpx2 %0b in frame %0d of pair", add_mpx2,
								frames_in_conv + 1));
					end
				end
				// bits[1] carries the MSB
				for (int i = 0; i < 8; i++) begin
					got[7 - i] = bits[i + 1];
				end
				assert (bits[9] == 1'b1) else report_failure("stop bit not high");
				assert (got == exp_byte) else report_failure(
					$sformatf("frame byte %02h, expected %02h", got, exp_byte));
				frames_in_conv++;
			end
		end
	end

	initial begin : main_sequence
		rst = 1'b1;
		eoc = 1'b0;
		dsr = 1'b1;
		data_in = 8'h00;
		exp_byte = 8'h00;
		mon_conv = 0;
		frames_in_conv = 0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_reset_state();
		// fifth reset edge, then release
		@(posedge clock);
		rst <= 1'b0;
		while (!(mon_conv == NUM_CONV && frames_in_conv == 2)) begin
			@(negedge clock);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
design/acq_pkg.sv
design/conv_sequencer.sv
design/tx_scheduler.sv
design/line_interface.sv
design/uart_serializer.sv
design/acq_top.sv
verif/acq_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= acq_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

# builds the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status is non-zero when the testbench stops with $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
